/* common/scanner_consts.svh */
// Preamble and SFD values, frame limits, octet offsets and configuration memory map
`ifndef SCANNER_CONSTS_SVH
`define SCANNER_CONSTS_SVH

// GMII preamble octet and start-of-frame delimiter
`define PREAMBLE      8'h55
`define SFD           8'hD5

// Idle plus preamble cycles required before a new SFD
`define IFG_MIN       10
// Frame is dropped when the octet count reaches this
`define MAX_FRAME     1536
// 14 header octets and 4 FCS octets around the IP datagram
`define ETH_OVERHEAD  18
`define IP_HDR_LEN    20
`define IP_PROTO_UDP  8'h11

// Octet offsets, counted from the first octet after the SFD
`define OFF_DST_MAC   0
`define OFF_SRC_MAC   6
`define OFF_ETHERTYPE 12
`define OFF_IP_LEN    16
`define OFF_TTL       22
`define OFF_PROTO     23
`define OFF_IP_DST    30
`define OFF_UDP_SRC   34
`define OFF_UDP_DST   36
`define OFF_UDP_LEN   38
`define OFF_ARP_TIP   38

// Address sizes in octets
`define MAC_LEN       6
`define IPV4_LEN      4

// Configuration memory map
`define CFG_MAC_BASE  0
`define CFG_IP_BASE   6

`endif

/* common/scanner_pkg.sv */
// Octet, counter, length, address, category and status types of the frame scanner
`default_nettype none

package scanner_pkg;

	// One GMII data octet
	typedef logic [7:0] octet_t;

	// Octet position after the SFD, also used as frame length
	typedef logic [10:0] pack_cnt_t;

	// IP total length or UDP length field
	typedef logic [15:0] length16_t;

	// Address into the MAC/IP configuration memory
	typedef logic [3:0] cfg_addr_t;

	// Frame category, value 2 is held back for later use
	typedef enum logic [1:0] {
		CAT_OTHER    = 2'd0,
		CAT_ARP      = 2'd1,
		CAT_RESERVED = 2'd2,
		CAT_UDP      = 2'd3
	} category_t;

	// End-of-frame summary, category in the low bits
	typedef struct packed {
		logic      pass_ip;
		logic      pass_ethmac;
		category_t category;
	} status_t;

endpackage

`default_nettype wire

/* flist.f */
+incdir+common
common/scanner_pkg.sv
src/frame_rx.sv
src/addr_match.sv
patt/arp_patt.sv
patt/ip_patt.sv
patt/udp_patt.sv
src/classify.sv
src/scanner.sv
tb/scanner_asserts.sv
tb/scanner_tb.sv

/* patt/arp_patt.sv */
// ARP request template checker over the ethertype and fixed ARP header fields
`timescale 1ns/10ps
`default_nettype none
`include "scanner_consts.svh"

module arp_patt
	import scanner_pkg::*;
(
	input  wire            clk,
	input  wire            reset,
	input  wire pack_cnt_t pack_cnt,
	input  wire octet_t    data_d1,
	output logic           pass
);

	octet_t tmpl;
	logic   want;

	// Template ROM, registered so it lines up with data_d1
	always_ff @(posedge clk) begin
		case (pack_cnt)
			`OFF_ETHERTYPE:     tmpl <= 8'h08;
			`OFF_ETHERTYPE + 1: tmpl <= 8'h06;
			// Hardware type Ethernet
			`OFF_ETHERTYPE + 2: tmpl <= 8'h00;
			`OFF_ETHERTYPE + 3: tmpl <= 8'h01;
			// Protocol type IPv4
			`OFF_ETHERTYPE + 4: tmpl <= 8'h08;
			`OFF_ETHERTYPE + 5: tmpl <= 8'h00;
			// MAC and IP address lengths
			`OFF_ETHERTYPE + 6: tmpl <= 8'h06;
			`OFF_ETHERTYPE + 7: tmpl <= 8'h04;
			// Opcode 1 is request
			`OFF_ETHERTYPE + 8: tmpl <= 8'h00;
			`OFF_ETHERTYPE + 9: tmpl <= 8'h01;
			default:            tmpl <= 8'h00;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			want <= 1'b0;
			pass <= 1'b0;
		end else begin
			want <= pack_cnt >= `OFF_ETHERTYPE && pack_cnt < `OFF_ETHERTYPE + 10;
			if (pack_cnt == '0)
				pass <= 1'b1;
			else if (want && data_d1 != tmpl)
				pass <= 1'b0;
		end
	end

endmodule

`default_nettype wire

/* patt/ip_patt.sv */
// IPv4 header template checker with TTL reject and total-length capture
`timescale 1ns/10ps
`default_nettype none
`include "scanner_consts.svh"

module ip_patt
	import scanner_pkg::*;
(
	input  wire            clk,
	input  wire            reset,
	input  wire pack_cnt_t pack_cnt,
	input  wire octet_t    data_d1,
	output logic           pass,
	output length16_t      ip_length
);

	octet_t tmpl;
	octet_t df_mask;
	octet_t data_d;
	logic   want;
	logic   mask_df;
	logic   ttl_flag;
	logic   match;

	// Ethertype, version/IHL and flags/fragment, others are ignored
	always_ff @(posedge clk) begin
		case (pack_cnt)
			`OFF_ETHERTYPE:     tmpl <= 8'h08;
			`OFF_ETHERTYPE + 1: tmpl <= 8'h00;
			// Version 4 with a 20 octet header only
			`OFF_ETHERTYPE + 2: tmpl <= 8'h45;
			`OFF_ETHERTYPE + 8: tmpl <= 8'h00;
			`OFF_ETHERTYPE + 9: tmpl <= 8'h00;
			default:            tmpl <= 8'h00;
		endcase
	end

	// DF may be set, MF and the fragment offset may not
	assign df_mask = {1'b1, ~mask_df, 6'h3f};
	assign match = (data_d1 & df_mask) == tmpl;

	always_ff @(posedge clk) begin
		if (reset) begin
			want <= 1'b0;
			mask_df <= 1'b0;
			ttl_flag <= 1'b0;
			pass <= 1'b0;
		end else begin
			want <= (pack_cnt >= `OFF_ETHERTYPE && pack_cnt < `OFF_ETHERTYPE + 3) ||
				pack_cnt == `OFF_ETHERTYPE + 8 || pack_cnt == `OFF_ETHERTYPE + 9;
			mask_df <= pack_cnt == `OFF_ETHERTYPE + 8;
			ttl_flag <= pack_cnt == `OFF_TTL;
			if (pack_cnt == '0)
				pass <= 1'b1;
			else if ((want & ~match) || (ttl_flag && data_d1 == 8'h00))
				pass <= 1'b0;
		end
	end

	// Total length, big endian, cleared between frames
	always_ff @(posedge clk) begin
		data_d <= data_d1;
		if (pack_cnt == '0)
			ip_length <= '0;
		else if (pack_cnt == `OFF_IP_LEN + 2)
			ip_length <= {data_d, data_d1};
	end

endmodule

`default_nettype wire

/* patt/udp_patt.sv */
// UDP protocol checker with trusted source port and port-zero rejects and UDP length capture
`timescale 1ns/10ps
`default_nettype none
`include "scanner_consts.svh"

module udp_patt
	import scanner_pkg::*;
(
	input  wire            clk,
	input  wire            reset,
	input  wire pack_cnt_t pack_cnt,
	input  wire octet_t    data_d1,
	output logic           pass,
	output length16_t      udp_length
);

	octet_t data_d;
	logic   want;
	logic   reject_low;
	logic   discard_port0;

	// Source port below 1024 means a trusted service, never answer it
	// keeps echo loops from forming
	assign reject_low = pack_cnt == `OFF_UDP_SRC + 1 && data_d1[7:2] == 6'd0;

	// Both destination port octets zero
	assign discard_port0 = pack_cnt == `OFF_UDP_DST + 2 &&
		data_d == 8'h00 && data_d1 == 8'h00;

	always_ff @(posedge clk) begin
		if (reset) begin
			want <= 1'b0;
			pass <= 1'b0;
		end else begin
			// Protocol octet shows up on data_d1 next cycle
			want <= pack_cnt == `OFF_PROTO;
			if (pack_cnt == '0)
				pass <= 1'b1;
			else if ((want && data_d1 != `IP_PROTO_UDP) || reject_low || discard_port0)
				pass <= 1'b0;
		end
	end

	// UDP length covers header and data
	always_ff @(posedge clk) begin
		data_d <= data_d1;
		if (pack_cnt == '0)
			udp_length <= '0;
		else if (pack_cnt == `OFF_UDP_LEN + 2)
			udp_length <= {data_d, data_d1};
	end

endmodule

`default_nettype wire

/* src/addr_match.sv */
// Configuration memory address generator with destination MAC, ARP target and IP destination matching
`timescale 1ns/10ps
`default_nettype none
`include "scanner_consts.svh"

module addr_match
	import scanner_pkg::*;
(
	input  wire            clk,
	input  wire            reset,
	input  wire pack_cnt_t pack_cnt,
	input  wire octet_t    data_d1,
	input  wire octet_t    ip_d,
	output cfg_addr_t      ip_a,
	output logic           pass_ethmac,
	output logic           pass_arpip,
	output logic           pass_ipdst
);

	logic in_eth;
	logic in_arp;
	logic in_ip;
	logic want_eth;
	logic want_arp;
	logic want_ip;
	logic ip_m;

	// Compare windows in frame position
	assign in_eth = pack_cnt < `OFF_DST_MAC + `MAC_LEN;
	assign in_arp = pack_cnt >= `OFF_ARP_TIP && pack_cnt < `OFF_ARP_TIP + `IPV4_LEN;
	assign in_ip = pack_cnt >= `OFF_IP_DST && pack_cnt < `OFF_IP_DST + `IPV4_LEN;

	// Address one cycle ahead of the octet it is compared with
	always_comb begin
		if (in_arp)
			ip_a = cfg_addr_t'(`CFG_IP_BASE + pack_cnt - `OFF_ARP_TIP);
		else if (in_ip)
			ip_a = cfg_addr_t'(`CFG_IP_BASE + pack_cnt - `OFF_IP_DST);
		else if (in_eth)
			ip_a = cfg_addr_t'(`CFG_MAC_BASE + pack_cnt - `OFF_DST_MAC);
		else
			ip_a = '0;
	end

	// Memory octet and frame octet meet here
	assign ip_m = ip_d == data_d1;

	always_ff @(posedge clk) begin
		if (reset) begin
			want_eth <= 1'b0;
			want_arp <= 1'b0;
			want_ip <= 1'b0;
			pass_ethmac <= 1'b0;
			pass_arpip <= 1'b0;
			pass_ipdst <= 1'b0;
		end else begin
			want_eth <= in_eth;
			want_arp <= in_arp;
			want_ip <= in_ip;
			// Re-arm between frames, first mismatch sticks
			if (pack_cnt == '0) begin
				pass_ethmac <= 1'b1;
				pass_arpip <= 1'b1;
				pass_ipdst <= 1'b1;
			end else begin
				if (want_eth & ~ip_m)
					pass_ethmac <= 1'b0;
				if (want_arp & ~ip_m)
					pass_arpip <= 1'b0;
				if (want_ip & ~ip_m)
					pass_ipdst <= 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

/* src/classify.sv */
// Length checks, unicast source check, category merge and end-of-frame status
`timescale 1ns/10ps
`default_nettype none
`include "scanner_consts.svh"

module classify
	import scanner_pkg::*;
(
	input  wire            clk,
	input  wire            reset,
	input  wire pack_cnt_t pack_cnt,
	input  wire octet_t    data_d1,
	input  wire            in_data,
	input  wire            final_octet,
	input  wire            pass_ethmac,
	input  wire            pass_arpip,
	input  wire            pass_ipdst,
	input  wire            pass_arp0,
	input  wire            pass_ip0,
	input  wire            pass_udp0,
	input  wire length16_t ip_length,
	input  wire length16_t udp_length,
	output logic           status_valid,
	output status_t        status_vec,
	output pack_cnt_t      pack_len
);

	logic        unicast_src;
	logic [16:0] ip_need;
	logic [16:0] udp_need;
	logic        ip_len_ok;
	logic        udp_len_ok;
	logic        pass_arp;
	logic        pass_ip;
	logic        pass_udp;
	category_t   category;
	status_t     status_live;
	status_t     status_q;

	always_ff @(posedge clk) begin
		if (reset) begin
			unicast_src <= 1'b0;
			pack_len <= '0;
		end else begin
			// Group bit of the source MAC
			if (pack_cnt == '0)
				unicast_src <= 1'b1;
			else if (pack_cnt == `OFF_SRC_MAC + 1)
				unicast_src <= ~data_d1[0];
			// Ends up as the octet count after the SFD
			if (in_data)
				pack_len <= pack_cnt;
		end
	end

	// Frame must hold the whole datagram, datagram must hold the UDP part
	assign ip_need = {1'b0, ip_length} + 17'(`ETH_OVERHEAD);
	assign udp_need = {1'b0, udp_length} + 17'(`IP_HDR_LEN);
	assign ip_len_ok = 17'(pack_len) >= ip_need;
	assign udp_len_ok = {1'b0, ip_length} >= udp_need;

	assign pass_arp = unicast_src & pass_arp0 & pass_arpip;
	assign pass_ip = unicast_src & pass_ethmac & pass_ip0 & pass_ipdst & ip_len_ok;
	assign pass_udp = pass_ip & pass_udp0 & udp_len_ok;

	// UDP wins over ARP
	assign category = pass_udp ? CAT_UDP : pass_arp ? CAT_ARP : CAT_OTHER;

	assign status_live.pass_ip = pass_ip;
	assign status_live.pass_ethmac = pass_ethmac;
	assign status_live.category = category;

	// Flags re-arm after the frame, so keep a copy
	always_ff @(posedge clk) begin
		if (reset)
			status_q <= '0;
		else if (final_octet)
			status_q <= status_live;
	end

	assign status_vec = final_octet ? status_live : status_q;
	assign status_valid = final_octet;

endmodule

`default_nettype wire

/* src/frame_rx.sv */
// Preamble/SFD FSM, gap counter, enable synchronizer, octet counter and output delay
`timescale 1ns/10ps
`default_nettype none
`include "scanner_consts.svh"

module frame_rx
	import scanner_pkg::*;
(
	input  wire         clk,
	input  wire         reset,
	input  wire octet_t eth_in,
	input  wire         eth_in_s,
	input  wire         enable_rx,
	output pack_cnt_t   pack_cnt,
	output octet_t      data_d1,
	output logic        in_data,
	output logic        final_octet,
	output octet_t      odata,
	output logic        odata_s
);

	logic       enable_rx_r0;
	logic       enable_rx_r;
	logic       h_idle;
	logic       h_preamble;
	logic       h_data;
	logic       h_drop;
	logic [3:0] ifg_count;
	logic       ifg_ok;
	logic       drop_packet;
	logic       h_data_d1;

	assign ifg_ok = ifg_count >= `IFG_MIN;
	assign drop_packet = pack_cnt >= `MAX_FRAME;

	// Enable comes from another clock domain
	always_ff @(posedge clk) begin
		if (reset) begin
			enable_rx_r0 <= 1'b0;
			enable_rx_r <= 1'b0;
		end else begin
			enable_rx_r0 <= enable_rx;
			enable_rx_r <= enable_rx_r0;
		end
	end

	// Counts idle and preamble cycles, sticks at all ones
	always_ff @(posedge clk) begin
		if (reset)
			ifg_count <= '0;
		else if (h_idle | h_preamble)
			ifg_count <= ifg_count + {3'b000, ~&ifg_count};
		else
			ifg_count <= '0;
	end

	// One-hot receive FSM
	always_ff @(posedge clk) begin
		if (reset) begin
			h_idle <= 1'b1;
			h_preamble <= 1'b0;
			h_data <= 1'b0;
			h_drop <= 1'b0;
		end else begin
			// First octet must be preamble and reception must be on
			if (h_idle & eth_in_s) begin
				h_idle <= 1'b0;
				if (eth_in == `PREAMBLE && enable_rx_r)
					h_preamble <= 1'b1;
				else
					h_drop <= 1'b1;
			end
			if (h_preamble) begin
				if (~eth_in_s) begin
					h_preamble <= 1'b0;
					h_idle <= 1'b1;
				end else if (eth_in == `SFD) begin
					h_preamble <= 1'b0;
					// Short gap kills the frame
					h_data <= ifg_ok;
					h_drop <= ~ifg_ok;
				end else if (eth_in != `PREAMBLE) begin
					h_preamble <= 1'b0;
					h_drop <= 1'b1;
				end
			end
			if (h_data) begin
				if (~eth_in_s) begin
					h_data <= 1'b0;
					h_idle <= 1'b1;
				end else if (drop_packet) begin
					h_data <= 1'b0;
					h_drop <= 1'b1;
				end
			end
			// Wait out the rest of a rejected frame
			if (h_drop & ~eth_in_s) begin
				h_drop <= 1'b0;
				h_idle <= 1'b1;
			end
		end
	end

	// Octet counter and data-valid delay line
	always_ff @(posedge clk) begin
		if (reset) begin
			pack_cnt <= '0;
			h_data_d1 <= 1'b0;
			odata_s <= 1'b0;
		end else begin
			pack_cnt <= h_data ? pack_cnt + 11'd1 : '0;
			h_data_d1 <= h_data;
			// Data state lasts one cycle past the last octet, trim it here
			odata_s <= h_data & h_data_d1;
		end
	end

	// Squelched two-stage octet delay
	always_ff @(posedge clk) begin
		data_d1 <= eth_in_s ? eth_in : 8'h00;
		odata <= data_d1;
	end

	assign in_data = h_data;
	// Lines up with the last octet on odata
	assign final_octet = h_data_d1 & ~h_data;

endmodule

`default_nettype wire

/* src/scanner.sv */
// Top level of the receive frame scanner
`timescale 1ns/10ps
`default_nettype none

module scanner
	import scanner_pkg::*;
(
	input  wire         clk,
	input  wire         reset,
	input  wire octet_t eth_in,
	input  wire         eth_in_s,
	input  wire         enable_rx,
	output cfg_addr_t   ip_a,
	input  wire octet_t ip_d,
	output octet_t      odata,
	output logic        odata_s,
	output logic        odata_f,
	output logic        status_valid,
	output status_t     status_vec,
	output pack_cnt_t   pack_len
);

	pack_cnt_t pack_cnt;
	octet_t    data_d1;
	logic      in_data;
	logic      final_octet;
	logic      pass_ethmac;
	logic      pass_arpip;
	logic      pass_ipdst;
	logic      pass_arp0;
	logic      pass_ip0;
	logic      pass_udp0;
	length16_t ip_length;
	length16_t udp_length;

	// Framing, counting and the output delay
	frame_rx rx (.clk(clk), .reset(reset), .eth_in(eth_in), .eth_in_s(eth_in_s),
		.enable_rx(enable_rx), .pack_cnt(pack_cnt), .data_d1(data_d1), .in_data(in_data),
		.final_octet(final_octet), .odata(odata), .odata_s(odata_s));

	// Our MAC and IP from the configuration memory
	addr_match am (.clk(clk), .reset(reset), .pack_cnt(pack_cnt), .data_d1(data_d1),
		.ip_d(ip_d), .ip_a(ip_a), .pass_ethmac(pass_ethmac), .pass_arpip(pass_arpip),
		.pass_ipdst(pass_ipdst));

	// Protocol checkers
	arp_patt arp_p (.clk(clk), .reset(reset), .pack_cnt(pack_cnt), .data_d1(data_d1),
		.pass(pass_arp0));
	ip_patt ip_p (.clk(clk), .reset(reset), .pack_cnt(pack_cnt), .data_d1(data_d1),
		.pass(pass_ip0), .ip_length(ip_length));
	udp_patt udp_p (.clk(clk), .reset(reset), .pack_cnt(pack_cnt), .data_d1(data_d1),
		.pass(pass_udp0), .udp_length(udp_length));

	classify cls (.clk(clk), .reset(reset), .pack_cnt(pack_cnt), .data_d1(data_d1),
		.in_data(in_data), .final_octet(final_octet), .pass_ethmac(pass_ethmac),
		.pass_arpip(pass_arpip), .pass_ipdst(pass_ipdst), .pass_arp0(pass_arp0),
		.pass_ip0(pass_ip0), .pass_udp0(pass_udp0), .ip_length(ip_length),
		.udp_length(udp_length), .status_valid(status_valid), .status_vec(status_vec),
		.pack_len(pack_len));

	// Last odata octet of a frame
	assign odata_f = final_octet;

endmodule

`default_nettype wire

/* tb/scanner_asserts.sv */
// Concurrent assertions on the scanner status and output strobes
`timescale 1ns/10ps
`default_nettype none

module scanner_asserts (
	input wire clk,
	input wire reset,
	input wire odata_s,
	input wire odata_f,
	input wire status_valid
);

	// Number of failed properties
	int unsigned fail_count = 0;

	// Status pulse and last-octet flag come together on an output octet
	status_is_last: assert property (@(posedge clk) disable iff (reset)
		(status_valid || odata_f) |-> status_valid && odata_f && odata_s)
		else begin
			$error("status_valid and odata_f not together on an output octet");
			fail_count++;
		end

	// Output strobe drops right after the last octet
	strobe_after_last: assert property (@(posedge clk) disable iff (reset)
		status_valid |=> !odata_s)
		else begin
			$error("odata_s still high after the status pulse");
			fail_count++;
		end

	// One pulse per frame
	status_single: assert property (@(posedge clk) disable iff (reset)
		status_valid |=> !status_valid)
		else begin
			$error("status_valid high in two consecutive cycles");
			fail_count++;
		end

	// Output strobe quiet while in reset
	strobe_reset: assert property (@(posedge clk) reset |=> !odata_s)
		else begin
			$error("odata_s high during reset");
			fail_count++;
		end

endmodule

`default_nettype wire

/* tb/scanner_tb.sv */
// Table-driven testbench for the frame scanner with frame builder, memory model and checks
`timescale 1ns/10ps
`default_nettype none
`include "scanner_consts.svh"

module scanner_tb
	import scanner_pkg::*;
;

	localparam logic [1:0] KIND_UDP = 2'd0;
	localparam logic [1:0] KIND_ARP = 2'd1;
	// UDP frame with a corrupted preamble octet
	localparam logic [1:0] KIND_BADPRE = 2'd2;
	localparam logic [47:0] OUR_MAC = 48'h02_0A_35_00_00_01;
	localparam logic [47:0] BCAST_MAC = 48'hFF_FF_FF_FF_FF_FF;
	localparam logic [31:0] OUR_IP = 32'hC0_A8_01_0A;
	localparam logic [31:0] SRC_IP = 32'hC0_A8_01_05;

	typedef struct packed {
		logic [1:0]  kind;
		logic        enable;
		logic [7:0]  gap;
		logic [47:0] dst_mac;
		logic        src_mcast;
		logic [31:0] tip;
		logic [7:0]  ttl;
		logic [15:0] sport;
		logic [15:0] dport;
		logic [10:0] plen;
	} row_t;

	logic      clk;
	logic      reset;
	octet_t    eth_in;
	logic      eth_in_s;
	logic      enable_rx;
	cfg_addr_t ip_a;
	octet_t    ip_d;
	octet_t    odata;
	logic      odata_s;
	logic      odata_f;
	logic      status_valid;
	status_t   status_vec;
	pack_cnt_t pack_len;

	row_t      rows[$];
	octet_t    frame_q[$];
	status_t   exp_status_q[$];
	pack_cnt_t exp_len_q[$];
	octet_t    exp_data_q[$];
	octet_t    cfg_mem[16];
	cfg_addr_t mem_addr;
	int        wd_limit = 0;

	scanner UUT (.clk(clk), .reset(reset), .eth_in(eth_in), .eth_in_s(eth_in_s),
		.enable_rx(enable_rx), .ip_a(ip_a), .ip_d(ip_d), .odata(odata), .odata_s(odata_s),
		.odata_f(odata_f), .status_valid(status_valid), .status_vec(status_vec),
		.pack_len(pack_len));

	bind scanner scanner_asserts sa (.clk(clk), .reset(reset), .odata_s(odata_s),
		.odata_f(odata_f), .status_valid(status_valid));

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// Configuration memory, one cycle read latency
	always @(negedge clk)
		mem_addr = ip_a;
	always @(posedge clk) begin
		#5;
		ip_d = cfg_mem[mem_addr];
	end

	task automatic abort_run(input string why);
		$display("%s", why);
		$display(">>> FAIL");
		$fatal(1);
	endtask

	task automatic compare_status(input status_t got, input status_t exp);
		if (got !== exp) begin
			$display("MISMATCH at %0t: status_vec got %b expected %b", $time, got, exp);
			abort_run("status check failed");
		end
	endtask

	task automatic compare_len(input pack_cnt_t got, input pack_cnt_t exp);
		if (got !== exp) begin
			$display("MISMATCH at %0t: pack_len got %0d expected %0d", $time, got, exp);
			abort_run("length check failed");
		end
	endtask

	task automatic compare_octet(input octet_t got, input octet_t exp);
		if (got !== exp) begin
			$display("MISMATCH at %0t: odata got %h expected %h", $time, got, exp);
			abort_run("output data check failed");
		end
	endtask

	task automatic compare_flag(input logic got, input logic exp, input string name);
		if (got !== exp) begin
			$display("MISMATCH at %0t: %s got %b expected %b", $time, name, got, exp);
			abort_run("flag check failed");
		end
	endtask

	task automatic add_row(input logic [1:0] kind, input logic enable, input logic [7:0] gap,
		input logic [47:0] dst_mac, input logic src_mcast, input logic [31:0] tip,
		input logic [7:0] ttl, input logic [15:0] sport, input logic [15:0] dport,
		input logic [10:0] plen);
		rows.push_back({kind, enable, gap, dst_mac, src_mcast, tip, ttl, sport, dport, plen});
	endtask

	// Category and pass flags from the classification rules
	function automatic status_t expect_status(input row_t r);
		status_t s;
		logic    mac_ok;
		logic    ip_ok;
		logic    udp_ok;
		logic    arp_ok;
		mac_ok = r.dst_mac == OUR_MAC;
		ip_ok = 1'b0;
		udp_ok = 1'b0;
		arp_ok = 1'b0;
		if (r.kind == KIND_ARP) begin
			arp_ok = !r.src_mcast && r.tip == OUR_IP;
		end else begin
			ip_ok = !r.src_mcast && mac_ok && r.ttl != 8'd0 && r.tip == OUR_IP;
			udp_ok = ip_ok && r.sport >= 16'd1024 && r.dport != 16'd0;
		end
		s.pass_ip = ip_ok;
		s.pass_ethmac = mac_ok;
		s.category = udp_ok ? CAT_UDP : arp_ok ? CAT_ARP : CAT_OTHER;
		return s;
	endfunction

	function automatic logic expect_drop(input row_t r);
		return r.kind == KIND_BADPRE || !r.enable || r.gap < `IFG_MIN;
	endfunction

	// Octets after the SFD, FCS included
	function automatic int frame_octets(input row_t r);
		return (r.kind == KIND_ARP) ? 64 : 46 + int'(r.plen);
	endfunction

	// Big endian, n octets from the low end of v
	task automatic append_octets(input logic [47:0] v, input int n);
		int k;
		for (k = n - 1; k >= 0; k--)
			frame_q.push_back(v[8*k +: 8]);
	endtask

	task automatic build_frame(input row_t r);
		logic [47:0] src_mac;
		int          k;
		src_mac = {r.src_mcast ? 8'h01 : 8'h02, 40'h11_22_33_44_55};
		frame_q.delete();
		append_octets(r.dst_mac, 6);
		append_octets(src_mac, 6);
		if (r.kind == KIND_ARP) begin
			// Ethertype, hardware and protocol type, address sizes, request
			append_octets(48'h0806_0001_0800, 6);
			append_octets(32'h0604_0001, 4);
			append_octets(src_mac, 6);
			append_octets(SRC_IP, 4);
			append_octets(48'h0, 6);
			append_octets(r.tip, 4);
			// Pad up to minimum size
			for (k = 0; k < 18; k++)
				append_octets($urandom, 1);
		end else begin
			append_octets(32'h0800_4500, 4);
			append_octets({5'd0, r.plen} + 16'd28, 2);
			// Identification, then DF set
			append_octets(32'h1234_4000, 4);
			append_octets({r.ttl, 8'h11, 16'h0000}, 4);
			append_octets(SRC_IP, 4);
			append_octets(r.tip, 4);
			append_octets({r.sport, r.dport}, 4);
			append_octets({{5'd0, r.plen} + 16'd8, 16'h0000}, 4);
			for (k = 0; k < r.plen; k++)
				append_octets($urandom, 1);
		end
		// FCS not checked here
		for (k = 0; k < 4; k++)
			append_octets($urandom, 1);
	endtask

	task automatic drive_octet(input octet_t d, input logic s);
		@(posedge clk);
		#5;
		eth_in = d;
		eth_in_s = s;
	endtask

	// Gap, preamble, SFD and frame body
	task automatic send_row(input row_t r);
		int k;
		build_frame(r);
		enable_rx = r.enable;
		repeat (r.gap)
			drive_octet(8'h00, 1'b0);
		if (!expect_drop(r)) begin
			if (exp_status_q.size() != 0)
				abort_run("status_valid missing for the previous frame");
			exp_status_q.push_back(expect_status(r));
			exp_len_q.push_back(pack_cnt_t'(frame_q.size()));
			foreach (frame_q[k])
				exp_data_q.push_back(frame_q[k]);
		end
		for (k = 0; k < 7; k++)
			drive_octet((r.kind == KIND_BADPRE && k == 3) ? 8'h5A : `PREAMBLE, 1'b1);
		drive_octet(`SFD, 1'b1);
		foreach (frame_q[k])
			drive_octet(frame_q[k], 1'b1);
	endtask

	// Output monitor, sampled mid-cycle
	always @(negedge clk) begin
		if (!reset) begin
			if (status_valid) begin
				if (exp_status_q.size() == 0) begin
					abort_run("status_valid seen for a frame that should be dropped");
				end else begin
					compare_status(status_vec, exp_status_q.pop_front());
					compare_len(pack_len, exp_len_q.pop_front());
				end
			end
			if (odata_s) begin
				if (exp_data_q.size() == 0) begin
					abort_run("odata_s high with no accepted frame pending");
				end else begin
					compare_octet(odata, exp_data_q.pop_front());
					compare_flag(odata_f, exp_data_q.size() == 0, "odata_f");
				end
			end else begin
				compare_flag(odata_f, 1'b0, "odata_f");
			end
		end
	end

	initial begin
		wait (wd_limit != 0);
		repeat (wd_limit)
			@(posedge clk);
		abort_run("timeout, the frame table did not finish in time");
	end

	// Any failed output assertion ends the run at once
	initial begin
		wait (UUT.sa.fail_count != 0);
		abort_run("an assertion on the scanner outputs failed");
	end

	initial begin
		int i;
		int total;
		int waited;
		reset = 1'b1;
		eth_in = 8'h00;
		eth_in_s = 1'b0;
		enable_rx = 1'b0;
		ip_d = 8'h00;
		mem_addr = '0;
		void'($urandom(92));
		for (i = 0; i < 16; i++)
			cfg_mem[i] = 8'hC0 | 8'(i);
		for (i = 0; i < 6; i++)
			cfg_mem[`CFG_MAC_BASE + i] = OUR_MAC[8*(5-i) +: 8];
		for (i = 0; i < 4; i++)
			cfg_mem[`CFG_IP_BASE + i] = OUR_IP[8*(3-i) +: 8];

		// kind, enable, gap, dst MAC, src multicast, target IP, TTL, sport, dport, payload
		add_row(KIND_UDP, 1, 12, OUR_MAC, 0, OUR_IP, 64, 5000, 7, 10);
		add_row(KIND_ARP, 1, 12, BCAST_MAC, 0, OUR_IP, 0, 0, 0, 0);
		add_row(KIND_UDP, 1, 12, 48'h02_00_00_00_00_99, 0, OUR_IP, 64, 5000, 7, 12);
		add_row(KIND_UDP, 1, 12, OUR_MAC, 0, OUR_IP, 0, 5000, 7, 8);
		add_row(KIND_UDP, 1, 12, OUR_MAC, 0, OUR_IP, 64, 53, 7, 8);
		add_row(KIND_UDP, 1, 12, OUR_MAC, 1, OUR_IP, 64, 5000, 7, 8);
		add_row(KIND_UDP, 1, 12, OUR_MAC, 0, OUR_IP, 64, 4000, 0, 6);
		add_row(KIND_BADPRE, 1, 12, OUR_MAC, 0, OUR_IP, 64, 5000, 7, 10);
		add_row(KIND_UDP, 1, 12, OUR_MAC, 0, OUR_IP, 32, 1024, 80, 20);
		add_row(KIND_UDP, 1, 1, OUR_MAC, 0, OUR_IP, 64, 5000, 7, 10);
		add_row(KIND_UDP, 0, 12, OUR_MAC, 0, OUR_IP, 64, 5000, 7, 10);
		add_row(KIND_UDP, 1, 12, OUR_MAC, 0, OUR_IP, 128, 60000, 9, 5);

		total = 8 + 200;
		foreach (rows[i])
			total += int'(rows[i].gap) + 8 + frame_octets(rows[i]);
		wd_limit = total;

		repeat (8)
			@(posedge clk);
		#5;
		reset = 1'b0;

		foreach (rows[i])
			send_row(rows[i]);
		drive_octet(8'h00, 1'b0);

		// Wait for the last status pulse, then a few idle cycles
		waited = 0;
		while (exp_status_q.size() != 0 && waited < 20) begin
			@(negedge clk);
			waited++;
		end
		repeat (4)
			@(negedge clk);

		if (exp_status_q.size() != 0 || exp_data_q.size() != 0) begin
			abort_run("status_valid or output data missing for the last frame");
		end else begin
			$display(">>> PASS");
			$finish;
		end
	end

endmodule

`default_nettype wire
